//--- tests/soc_cases.txt
# kind addr data sel expect rsp, all numbers in hex
# rtc sweep mip debug use data as a count or bits, irq data is meip seip, debug is en req
# boot rom contents and refused write
read  00001000 00000000 f b0070000 ack
read  00001004 00000000 f b0070001 ack
read  00001040 00000000 f b0070010 ack
read  000010fc 00000000 f b007003f ack
write 00001008 12345678 f 00000000 err
read  00001008 00000000 f b0070002 ack
# sram byte selects
write 80000000 deadbeef f 00000000 ack
write 80000000 00001234 3 00000000 ack
read  80000000 00000000 f dead1234 ack
write 80000004 11223344 f 00000000 ack
write 80000004 aabbccdd a 00000000 ack
read  80000004 00000000 f aa22cc44 ack
write 800000fc 0badf00d f 00000000 ack
read  800000fc 00000000 f 0badf00d ack
sweep 00000000 00000028 0 00000000 none
# unmapped addresses
read  40000000 00000000 f 00000000 err
read  80000100 00000000 f 00000000 err
write 80000100 00000001 f 00000000 err
read  02000010 00000000 f 00000000 err
read  00001100 00000000 f 00000000 err
# timer
read  02000000 00000000 f 00000000 ack
write 02000000 000000ff f 00000000 ack
read  02000000 00000000 f 00000000 ack
write 02000004 00000005 f 00000000 ack
read  02000004 00000000 f 00000005 ack
rtc   00000000 00000005 0 00000000 none
mip   00000000 00000004 0 00000080 none
read  02000000 00000000 f 00000005 ack
write 02000004 00000064 f 00000000 ack
mip   00000000 00000002 0 00000000 none
read  0200000c 00000000 f 00000000 ack
# interrupt vector
irq   00000000 00000003 0 00000000 none
write 02000008 00000001 1 00000000 ack
mip   00000000 00000001 0 00000a08 none
irq   00000000 00000000 0 00000000 none
write 02000008 00000000 1 00000000 ack
mip   00000000 00000001 0 00000000 none
# debug gate
debug 00000000 00000001 0 00000000 none
debug 00000000 00000003 0 00000000 none

//--- build.f
src/soc_pkg.sv
src/addr_decoder.sv
src/boot_rom.sv
src/sram.sv
src/clint_lite.sv
src/debug_gate.sv
src/soc_top.sv
tests/bus_checker.sv
tests/tb_top.sv

//--- Bender.yml
package:
  name: soc_harness

sources:
  - src/soc_pkg.sv
  - src/addr_decoder.sv
  - src/boot_rom.sv
  - src/sram.sv
  - src/clint_lite.sv
  - src/debug_gate.sv
  - src/soc_top.sv
  - target: test
    files:
      - tests/bus_checker.sv
      - tests/tb_top.sv

//--- tests/tb_top.sv
// ----------------------------------------------------------
// testbench top for the memory-mapped SoC
// reads operations from the case file, drives the Wishbone
// master port and sidebands; bus_checker does the comparing
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_top;

  localparam int unsigned NumRamWords      = 64;
  localparam int unsigned DebugDelayCycles = 20;
  localparam int unsigned Seed             = 25956;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             rtc;
  soc_pkg::wb_req_t wb_req;
  soc_pkg::wb_rsp_t wb_rsp;
  logic             meip;
  logic             seip;
  logic             dbg_req_in;
  logic             dbg_en;
  soc_pkg::data_t   mip;
  logic             dbg_req_out;
  // expectations handed to the checker with each access
  logic             exp_err;
  logic             exp_chk;
  logic             exp_model;
  soc_pkg::data_t   exp_dat;
  logic             mip_chk;
  soc_pkg::data_t   exp_mip;
  int               mismatch_cnt;
  int               fault_cnt;
  int               tb_errors = 0;
  logic             loaded = 1'b0;

  // case file columns
  logic [63:0]      kinds [$];
  soc_pkg::addr_t   addrs [$];
  soc_pkg::data_t   datas [$];
  soc_pkg::sel_t    sels [$];
  soc_pkg::data_t   exps [$];
  logic [63:0]      rsps [$];

  always #4 clk_i = ~clk_i;

  soc_top #(
    .NumRamWords      ( NumRamWords      ),
    .DebugDelayCycles ( DebugDelayCycles )
  ) dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc         ),
    .wb_req_i    ( wb_req      ),
    .meip_i      ( meip        ),
    .seip_i      ( seip        ),
    .debug_req_i ( dbg_req_in  ),
    .debug_en_i  ( dbg_en      ),
    .wb_rsp_o    ( wb_rsp      ),
    .mip_o       ( mip         ),
    .debug_req_o ( dbg_req_out )
  );

  bus_checker #(
    .NumRamWords      ( NumRamWords      ),
    .DebugDelayCycles ( DebugDelayCycles )
  ) i_bus_checker (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .wb_req_i       ( wb_req       ),
    .wb_rsp_i       ( wb_rsp       ),
    .mip_i          ( mip          ),
    .meip_i         ( meip         ),
    .seip_i         ( seip         ),
    .debug_req_i    ( dbg_req_in   ),
    .debug_en_i     ( dbg_en       ),
    .debug_gated_i  ( dbg_req_out  ),
    .exp_err_i      ( exp_err      ),
    .exp_chk_i      ( exp_chk      ),
    .exp_model_i    ( exp_model    ),
    .exp_dat_i      ( exp_dat      ),
    .mip_chk_i      ( mip_chk      ),
    .exp_mip_i      ( exp_mip      ),
    .mismatch_cnt_o ( mismatch_cnt ),
    .fault_cnt_o    ( fault_cnt    )
  );

  task automatic wait_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic load_cases();
    int             fd;
    int             n;
    logic [63:0]    tok;
    logic [1023:0]  rest;
    soc_pkg::addr_t a;
    soc_pkg::data_t d;
    soc_pkg::sel_t  s;
    soc_pkg::data_t e;
    logic [63:0]    r;
    fd = $fopen("tests/soc_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file tests/soc_cases.txt");
      tb_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) break;
      if (tok == "#") begin
        n = $fgets(rest, fd);
      end else begin
        n = $fscanf(fd, "%h %h %h %h %s", a, d, s, e, r);
        if (n != 5) begin
          $display("malformed line in the case file after kind %0s", tok);
          tb_errors++;
          break;
        end
        kinds.push_back(tok);
        addrs.push_back(a);
        datas.push_back(d);
        sels.push_back(s);
        exps.push_back(e);
        rsps.push_back(r);
      end
    end
    $fclose(fd);
  endtask

  // one access; returns after the response and one idle cycle
  task automatic bus_access(input logic we, input soc_pkg::addr_t adr,
                            input soc_pkg::data_t dat, input soc_pkg::sel_t sel,
                            input logic err, input logic chk,
                            input soc_pkg::data_t edat, input logic model);
    int unsigned waited;
    exp_err   = err;
    exp_chk   = chk;
    exp_dat   = edat;
    exp_model = model;
    wb_req    = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
    waited    = 0;
    do begin
      @(posedge clk_i);
      #1;
      waited++;
    end while (!(wb_rsp.ack || wb_rsp.err) && waited < 4);
    wb_req = '0;
    wait_cycles(1);
  endtask

  task automatic rtc_pulses(input int unsigned count);
    repeat (count) begin
      rtc = 1'b1;
      wait_cycles(3);
      rtc = 1'b0;
      wait_cycles(3);
    end
  endtask

  // random byte-select writes, then read every written word back
  task automatic ram_sweep(input int unsigned count);
    soc_pkg::addr_t adrs [$];
    soc_pkg::addr_t a;
    for (int i = 0; i < count; i++) begin
      a = soc_pkg::RamBase + soc_pkg::addr_t'(($urandom % NumRamWords) * 4);
      adrs.push_back(a);
      bus_access(1'b1, a, $urandom, soc_pkg::sel_t'($urandom), 1'b0, 1'b0, '0, 1'b0);
    end
    foreach (adrs[i]) begin
      bus_access(1'b0, adrs[i], '0, 4'hf, 1'b0, 1'b0, '0, 1'b1);
    end
  endtask

  task automatic run_case(input int i);
    logic err;
    err = (rsps[i] == "err");
    case (kinds[i])
      "write": bus_access(1'b1, addrs[i], datas[i], sels[i], err, 1'b0, '0, 1'b0);
      "read":  bus_access(1'b0, addrs[i], datas[i], sels[i], err, 1'b1, exps[i], 1'b0);
      "rtc":   rtc_pulses(datas[i]);
      "sweep": ram_sweep(datas[i]);
      "irq": begin
        meip = datas[i][1];
        seip = datas[i][0];
        wait_cycles(1);
      end
      "mip": begin
        wait_cycles(datas[i]);
        exp_mip = exps[i];
        mip_chk = 1'b1;
        wait_cycles(1);
        mip_chk = 1'b0;
      end
      "debug": begin
        dbg_en     = datas[i][1];
        dbg_req_in = datas[i][0];
        wait_cycles(3);
      end
      default: begin
        $display("unknown operation %0s on case %0d", kinds[i], i);
        tb_errors++;
      end
    endcase
  endtask

  initial begin : main
    rst_ni     = 1'b0;
    rtc        = 1'b0;
    wb_req     = '0;
    meip       = 1'b0;
    seip       = 1'b0;
    dbg_req_in = 1'b1;
    dbg_en     = 1'b1;
    exp_err    = 1'b0;
    exp_chk    = 1'b0;
    exp_model  = 1'b0;
    exp_dat    = '0;
    mip_chk    = 1'b0;
    exp_mip    = '0;
    void'($urandom(Seed));
    load_cases();
    loaded = 1'b1;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    foreach (kinds[i]) begin
      run_case(i);
    end
    wait_cycles(4);
    $display("errors: %0d mismatches, %0d protocol faults, %0d testbench faults",
             mismatch_cnt, fault_cnt, tb_errors);
    if (mismatch_cnt == 0 && fault_cnt == 0 && tb_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog sized from the number of cases
  initial begin : watchdog
    wait (loaded);
    repeat (40 * kinds.size() + 200) @(posedge clk_i);
    $display("timeout after %0d cycles, the run did not complete", 40 * kinds.size() + 200);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- tests/bus_checker.sv
// ----------------------------------------------------------
// bus and sideband checker for the SoC testbench
// watches the DUT ports, keeps shadow copies of sram and
// clint registers, and counts mismatches and protocol faults
// ----------------------------------------------------------

`timescale 1ns/1ps

module bus_checker #(
  parameter int unsigned NumRamWords      = 64,
  parameter int unsigned DebugDelayCycles = 20
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t wb_req_i,
  input  soc_pkg::wb_rsp_t wb_rsp_i,
  input  soc_pkg::data_t   mip_i,
  input  logic             meip_i,
  input  logic             seip_i,
  input  logic             debug_req_i,
  input  logic             debug_en_i,
  input  logic             debug_gated_i,
  input  logic             exp_err_i,
  input  logic             exp_chk_i,
  input  logic             exp_model_i,
  input  soc_pkg::data_t   exp_dat_i,
  input  logic             mip_chk_i,
  input  soc_pkg::data_t   exp_mip_i,
  output int               mismatch_cnt_o,
  output int               fault_cnt_o
);

  soc_pkg::data_t   ram_q [NumRamWords];
  soc_pkg::data_t   ram_known [NumRamWords];
  soc_pkg::data_t   cmp_q;
  logic             msip_q;
  soc_pkg::wb_req_t req_q;
  logic             pend_q;
  int unsigned      age_q;
  logic             err_exp_q;
  logic             chk_q;
  logic             model_q;
  soc_pkg::data_t   dat_exp_q;
  int unsigned      since_rst;
  int               mismatches = 0;
  int               faults = 0;

  assign mismatch_cnt_o = mismatches;
  assign fault_cnt_o    = faults;

  function automatic logic in_ram(input soc_pkg::addr_t adr);
    return adr >= soc_pkg::RamBase && adr < soc_pkg::RamBase + NumRamWords * 4;
  endfunction

  task automatic report_mismatch(input string name, input soc_pkg::data_t exp,
                                 input soc_pkg::data_t act);
    $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
    mismatches++;
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    soc_pkg::data_t exp_d;
    soc_pkg::data_t mask;
    soc_pkg::data_t exp_m;
    logic           rsp_seen;
    logic           dbg_exp;
    int unsigned    idx;
    if (!rst_ni) begin
      pend_q    = 1'b0;
      age_q     = 0;
      since_rst = 0;
      msip_q    = 1'b0;
      cmp_q     = '1;
      for (int w = 0; w < NumRamWords; w++) begin
        ram_known[w] = '0;
      end
    end else begin
      rsp_seen = wb_rsp_i.ack | wb_rsp_i.err;
      idx      = ((req_q.adr - soc_pkg::RamBase) >> 2) % NumRamWords;

      // ----------------------------------------------------------
      // response to the strobe seen one edge earlier
      // ----------------------------------------------------------
      if (pend_q && rsp_seen) begin
        pend_q = 1'b0;
        if (wb_rsp_i.ack !== !err_exp_q) begin
          report_mismatch("wb_rsp_o.ack", !err_exp_q, wb_rsp_i.ack);
        end
        if (wb_rsp_i.err !== err_exp_q) begin
          report_mismatch("wb_rsp_o.err", err_exp_q, wb_rsp_i.err);
        end
        if (wb_rsp_i.ack && !req_q.we) begin
          exp_d = dat_exp_q;
          mask  = chk_q ? '1 : '0;
          if (model_q) begin
            mask = '0;
            if (in_ram(req_q.adr)) begin
              exp_d = ram_q[idx];
              mask  = ram_known[idx];
            end
          end
          // unknown sram bytes are left out of the compare
          if (((wb_rsp_i.dat ^ exp_d) & mask) !== '0) begin
            report_mismatch("wb_rsp_o.dat", exp_d & mask, wb_rsp_i.dat);
          end
          // mtimecmp reads also against the shadow register
          if (req_q.adr == soc_pkg::ClintBase + soc_pkg::MtimecmpOffset &&
              wb_rsp_i.dat !== cmp_q) begin
            report_mismatch("wb_rsp_o.dat", cmp_q, wb_rsp_i.dat);
          end
        end
        if (wb_rsp_i.ack && req_q.we) begin
          for (int b = 0; b < soc_pkg::SelWidth; b++) begin
            if (req_q.sel[b] && in_ram(req_q.adr)) begin
              ram_q[idx][b*8 +: 8]     = req_q.dat[b*8 +: 8];
              ram_known[idx][b*8 +: 8] = 8'hff;
            end
            if (req_q.sel[b] &&
                req_q.adr == soc_pkg::ClintBase + soc_pkg::MtimecmpOffset) begin
              cmp_q[b*8 +: 8] = req_q.dat[b*8 +: 8];
            end
          end
          if (req_q.adr == soc_pkg::ClintBase + soc_pkg::MsipOffset && req_q.sel[0]) begin
            msip_q = req_q.dat[0];
          end
        end
      end else if (pend_q) begin
        age_q++;
        faults++;
        if (age_q == 1) begin
          $display("%0t: no response one cycle after the strobe at %h", $time, req_q.adr);
        end else begin
          $display("%0t: no response within 2 cycles for access at %h", $time, req_q.adr);
          pend_q = 1'b0;
        end
      end else if (rsp_seen) begin
        $display("%0t: response seen without any pending access", $time);
        faults++;
      end

      // capture a fresh strobe and skip the tail of an answered one
      if (wb_req_i.cyc && wb_req_i.stb && !rsp_seen && !pend_q) begin
        req_q     = wb_req_i;
        err_exp_q = exp_err_i;
        chk_q     = exp_chk_i;
        model_q   = exp_model_i;
        dat_exp_q = exp_dat_i;
        age_q     = 0;
        pend_q    = 1'b1;
      end

      // ----------------------------------------------------------
      // mip and debug gate checked every cycle
      // ----------------------------------------------------------
      exp_m                   = '0;
      exp_m[soc_pkg::MsipBit] = msip_q;
      exp_m[soc_pkg::SeipBit] = seip_i;
      exp_m[soc_pkg::MeipBit] = meip_i;
      if (mip_chk_i) begin
        if (mip_i !== exp_mip_i) begin
          report_mismatch("mip_o", exp_mip_i, mip_i);
        end
      end else if (((mip_i ^ exp_m) & ~(soc_pkg::data_t'(1) << soc_pkg::MtipBit)) !== '0) begin
        // mtip only checked on request
        report_mismatch("mip_o", exp_m, mip_i);
      end

      dbg_exp = (since_rst >= DebugDelayCycles) && debug_en_i && debug_req_i;
      if (debug_gated_i !== dbg_exp) begin
        report_mismatch("debug_req_o", dbg_exp, debug_gated_i);
      end
      since_rst++;
    end
  end

endmodule

//--- src/soc_top.sv
// ----------------------------------------------------------
// top level of the memory-mapped test SoC
// one Wishbone master port in front of the decoder, which
// feeds boot rom, sram and clint; also carries mip and the
// gated debug request out to the hart side
// ----------------------------------------------------------

`timescale 1ns/1ps

module soc_top #(
  parameter int unsigned NumRamWords      = 256,
  parameter int unsigned DebugDelayCycles = 500
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             rtc_i,
  input  soc_pkg::wb_req_t wb_req_i,
  input  logic             meip_i,
  input  logic             seip_i,
  input  logic             debug_req_i,
  input  logic             debug_en_i,
  output soc_pkg::wb_rsp_t wb_rsp_o,
  output soc_pkg::data_t   mip_o,
  output logic             debug_req_o
);

  soc_pkg::wb_req_t rom_req;
  soc_pkg::wb_req_t ram_req;
  soc_pkg::wb_req_t clint_req;
  soc_pkg::wb_rsp_t rom_rsp;
  soc_pkg::wb_rsp_t ram_rsp;
  soc_pkg::wb_rsp_t clint_rsp;

  // ----------------------------------------------------------
  // bus fabric and slaves
  // ----------------------------------------------------------
  addr_decoder #(
    .NumRamWords ( NumRamWords )
  ) i_addr_decoder (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .wb_req_i    ( wb_req_i    ),
    .rom_rsp_i   ( rom_rsp     ),
    .ram_rsp_i   ( ram_rsp     ),
    .clint_rsp_i ( clint_rsp   ),
    .rom_req_o   ( rom_req     ),
    .ram_req_o   ( ram_req     ),
    .clint_req_o ( clint_req   ),
    .wb_rsp_o    ( wb_rsp_o    )
  );

  boot_rom i_boot_rom (
    .clk_i    ( clk_i   ),
    .rst_ni   ( rst_ni  ),
    .wb_req_i ( rom_req ),
    .wb_rsp_o ( rom_rsp )
  );

  sram #(
    .NumRamWords ( NumRamWords )
  ) i_sram (
    .clk_i    ( clk_i   ),
    .rst_ni   ( rst_ni  ),
    .wb_req_i ( ram_req ),
    .wb_rsp_o ( ram_rsp )
  );

  clint_lite i_clint_lite (
    .clk_i    ( clk_i     ),
    .rst_ni   ( rst_ni    ),
    .rtc_i    ( rtc_i     ),
    .wb_req_i ( clint_req ),
    .meip_i   ( meip_i    ),
    .seip_i   ( seip_i    ),
    .wb_rsp_o ( clint_rsp ),
    .mip_o    ( mip_o     )
  );

  // debug hold-off window
  debug_gate #(
    .DebugDelayCycles ( DebugDelayCycles )
  ) i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- src/debug_gate.sv
// ----------------------------------------------------------
// debug request gate for the hart
// holds requests off for DebugDelayCycles after reset so the
// boot code can run; debug_en_i blocks them altogether
// ----------------------------------------------------------

`timescale 1ns/1ps

module debug_gate #(
  parameter int unsigned DebugDelayCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  // at least one bit, even for a zero delay
  localparam int unsigned CntWidth =
    (DebugDelayCycles > 0) ? $clog2(DebugDelayCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic                window_done;

  assign window_done = (cnt_q == '0);

  // counts down once, then parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DebugDelayCycles);
    end else if (!window_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = window_done & debug_en_i & debug_req_i;

endmodule

//--- src/clint_lite.sv
// ----------------------------------------------------------
// reduced CLINT for one hart
// mtime counts rtc edges, mtimecmp and msip sit on the bus,
// and the machine interrupt-pending vector is built here
// ----------------------------------------------------------

`timescale 1ns/1ps

module clint_lite (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             rtc_i,
  input  soc_pkg::wb_req_t wb_req_i,
  input  logic             meip_i,
  input  logic             seip_i,
  output soc_pkg::wb_rsp_t wb_rsp_o,
  output soc_pkg::data_t   mip_o
);

  logic            strobe;
  logic            access;
  logic            wr_en;
  soc_pkg::addr_t  reg_off;
  logic [1:0]      rtc_sync_q;
  logic            rtc_prev_q;
  logic            rtc_rise;
  soc_pkg::data_t  mtime_q;
  soc_pkg::data_t  mtimecmp_q;
  logic            msip_q;
  logic            mtip_q;
  logic            ack_q;
  soc_pkg::data_t  dat_q;

  assign strobe  = wb_req_i.cyc & wb_req_i.stb;
  assign access  = strobe & ~ack_q;
  assign wr_en   = access & wb_req_i.we;
  // word offset inside the region
  assign reg_off = wb_req_i.adr & soc_pkg::addr_t'(soc_pkg::ClintLength - soc_pkg::SelWidth);

  // ----------------------------------------------------------
  // rtc sync and timer
  // ----------------------------------------------------------
  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      mtime_q    <= '0;
      mtip_q     <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      mtip_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // ----------------------------------------------------------
  // bus registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      ack_q <= access;
      // mtime itself is read-only, writes to it just ack
      if (wr_en && reg_off == soc_pkg::MtimecmpOffset) begin
        for (int b = 0; b < soc_pkg::SelWidth; b++) begin
          if (wb_req_i.sel[b]) begin
            mtimecmp_q[b*8 +: 8] <= wb_req_i.dat[b*8 +: 8];
          end
        end
      end
      if (wr_en && reg_off == soc_pkg::MsipOffset && wb_req_i.sel[0]) begin
        msip_q <= wb_req_i.dat[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !wb_req_i.we) begin
      case (reg_off)
        soc_pkg::MtimeOffset:    dat_q <= mtime_q;
        soc_pkg::MtimecmpOffset: dat_q <= mtimecmp_q;
        soc_pkg::MsipOffset:     dat_q <= soc_pkg::data_t'(msip_q);
        default:                 dat_q <= '0;
      endcase
    end
  end

  assign wb_rsp_o = '{ack: ack_q, err: 1'b0, dat: dat_q};

  // interrupt-pending vector at the RISC-V positions
  always_comb begin
    mip_o                   = '0;
    mip_o[soc_pkg::MsipBit] = msip_q;
    mip_o[soc_pkg::MtipBit] = mtip_q;
    mip_o[soc_pkg::SeipBit] = seip_i;
    mip_o[soc_pkg::MeipBit] = meip_i;
  end

endmodule

//--- src/sram.sv
// ----------------------------------------------------------
// single-port word sram on the Wishbone bus
// writes honour the byte selects, reads return the whole
// word; every access acks one cycle after the strobe
// ----------------------------------------------------------

`timescale 1ns/1ps

module sram #(
  parameter int unsigned NumRamWords = 256
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o
);

  localparam int unsigned OffsetBits = $clog2(soc_pkg::SelWidth);
  localparam int unsigned IdxBits    = $clog2(NumRamWords);

  soc_pkg::data_t     mem [NumRamWords];
  logic               strobe;
  logic               access;
  logic [IdxBits-1:0] word_idx;
  logic               ack_q;
  soc_pkg::data_t     dat_q;

  assign strobe   = wb_req_i.cyc & wb_req_i.stb;
  // first cycle of the strobe only
  assign access   = strobe & ~ack_q;
  assign word_idx = wb_req_i.adr[OffsetBits +: IdxBits];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // storage and read port
  always_ff @(posedge clk_i) begin
    if (access && wb_req_i.we) begin
      for (int b = 0; b < soc_pkg::SelWidth; b++) begin
        if (wb_req_i.sel[b]) begin
          mem[word_idx][b*8 +: 8] <= wb_req_i.dat[b*8 +: 8];
        end
      end
    end
    if (access && !wb_req_i.we) begin
      dat_q <= mem[word_idx];
    end
  end

  assign wb_rsp_o = '{ack: ack_q, err: 1'b0, dat: dat_q};

endmodule

//--- src/boot_rom.sv
// ----------------------------------------------------------
// boot rom with generated contents
// word k reads as RomSignature xor k; writes get an err
// ----------------------------------------------------------

`timescale 1ns/1ps

module boot_rom (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o
);

  localparam int unsigned OffsetBits = $clog2(soc_pkg::SelWidth);
  localparam int unsigned IdxBits    = $clog2(soc_pkg::RomLength) - OffsetBits;

  logic                strobe;
  logic                busy;
  logic [IdxBits-1:0]  word_idx;
  logic                ack_q;
  logic                err_q;
  soc_pkg::data_t      dat_q;

  assign strobe   = wb_req_i.cyc & wb_req_i.stb;
  assign busy     = ack_q | err_q;
  assign word_idx = wb_req_i.adr[OffsetBits +: IdxBits];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= strobe & ~busy & ~wb_req_i.we;
      err_q <= strobe & ~busy & wb_req_i.we;
    end
  end

  // read data
  always_ff @(posedge clk_i) begin
    if (strobe && !wb_req_i.we) begin
      dat_q <= soc_pkg::RomSignature ^ soc_pkg::data_t'(word_idx);
    end
  end

  assign wb_rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

//--- src/addr_decoder.sv
// ----------------------------------------------------------
// address decoder for the single Wishbone master
// routes the strobe to rom, ram or clint by the address map
// and answers unmapped accesses itself with a registered err
// ----------------------------------------------------------

`timescale 1ns/1ps

module addr_decoder #(
  parameter int unsigned NumRamWords = 256
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t wb_req_i,
  input  soc_pkg::wb_rsp_t rom_rsp_i,
  input  soc_pkg::wb_rsp_t ram_rsp_i,
  input  soc_pkg::wb_rsp_t clint_rsp_i,
  output soc_pkg::wb_req_t rom_req_o,
  output soc_pkg::wb_req_t ram_req_o,
  output soc_pkg::wb_req_t clint_req_o,
  output soc_pkg::wb_rsp_t wb_rsp_o
);

  localparam soc_pkg::addr_t RamLength = soc_pkg::addr_t'(NumRamWords * soc_pkg::SelWidth);

  soc_pkg::slave_e target;
  logic            strobe;
  logic            err_q;

  assign strobe = wb_req_i.cyc & wb_req_i.stb;

  // region match, base inclusive and end exclusive
  always_comb begin
    target = soc_pkg::SlvNone;
    if (wb_req_i.adr >= soc_pkg::RomBase &&
        wb_req_i.adr < soc_pkg::RomBase + soc_pkg::RomLength) begin
      target = soc_pkg::SlvRom;
    end else if (wb_req_i.adr >= soc_pkg::ClintBase &&
                 wb_req_i.adr < soc_pkg::ClintBase + soc_pkg::ClintLength) begin
      target = soc_pkg::SlvClint;
    end else if (wb_req_i.adr >= soc_pkg::RamBase &&
                 wb_req_i.adr < soc_pkg::RamBase + RamLength) begin
      target = soc_pkg::SlvRam;
    end
  end

  // only the selected slave sees stb
  always_comb begin
    rom_req_o       = wb_req_i;
    ram_req_o       = wb_req_i;
    clint_req_o     = wb_req_i;
    rom_req_o.stb   = wb_req_i.stb & (target == soc_pkg::SlvRom);
    ram_req_o.stb   = wb_req_i.stb & (target == soc_pkg::SlvRam);
    clint_req_o.stb = wb_req_i.stb & (target == soc_pkg::SlvClint);
  end

  // unmapped access, err one cycle later and never twice per strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= strobe & (target == soc_pkg::SlvNone) & ~err_q;
    end
  end

  // one slave strobed at a time, so a plain or is enough
  assign wb_rsp_o.ack = rom_rsp_i.ack | ram_rsp_i.ack | clint_rsp_i.ack;
  assign wb_rsp_o.err = rom_rsp_i.err | ram_rsp_i.err | clint_rsp_i.err | err_q;
  // read data only counts while ack is high
  assign wb_rsp_o.dat = ({soc_pkg::DataWidth{rom_rsp_i.ack}} & rom_rsp_i.dat)
                      | ({soc_pkg::DataWidth{ram_rsp_i.ack}} & ram_rsp_i.dat)
                      | ({soc_pkg::DataWidth{clint_rsp_i.ack}} & clint_rsp_i.dat);

endmodule

//--- src/soc_pkg.sv
// ----------------------------------------------------------
// shared definitions for the memory-mapped test SoC
// bus widths, Wishbone request/response structs, the address
// map and the CLINT register layout; modules refer to these
// by scoped names
// ----------------------------------------------------------

package soc_pkg;

  // bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [SelWidth-1:0]  sel_t;

  // ----------------------------------------------------------
  // Wishbone classic, master to slave and back
  // ----------------------------------------------------------
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    sel_t  sel;
    data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  // ----------------------------------------------------------
  // address map
  // ----------------------------------------------------------
  localparam addr_t RomBase     = 32'h0000_1000;
  localparam addr_t RomLength   = 32'h0000_0100;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0000_0010;
  // ram length is set by the NumRamWords parameter
  localparam addr_t RamBase     = 32'h8000_0000;

  // decoder target
  typedef enum logic [1:0] {
    SlvRom,
    SlvRam,
    SlvClint,
    SlvNone
  } slave_e;

  // rom word k reads as signature xor k
  localparam data_t RomSignature = 32'hB007_0000;

  // clint register offsets within its region
  localparam addr_t MtimeOffset    = 32'h0;
  localparam addr_t MtimecmpOffset = 32'h4;
  localparam addr_t MsipOffset     = 32'h8;

  // bit positions in mip
  localparam int unsigned MsipBit = 3;
  localparam int unsigned MtipBit = 7;
  localparam int unsigned SeipBit = 9;
  localparam int unsigned MeipBit = 11;

endpackage
